/* hw/sram_bridge_cfg.svh */
`ifndef SRAM_BRIDGE_CFG_SVH
`define SRAM_BRIDGE_CFG_SVH

// byte address width on the axi side
`define AXI_ADDR_W 32

// axi data bus width
`define AXI_DATA_W 32

// one strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// sram word index width
// word address is the byte address without its two low bits
`define SRAM_DEPTH_LOG2 8

// number of words in the sram array
`define SRAM_DEPTH (1 << `SRAM_DEPTH_LOG2)

// lowest byte-address bit that selects a word
`define SRAM_WORD_LSB 2

`endif

/* hw/sram_bridge_pkg.sv */
package sram_bridge_pkg;

   // write channel sequence
   // address and data may arrive in either order
   typedef enum logic [1:0] {
      // nothing captured yet
      wr_idle      = 2'd0,
      // address held, waiting for data
      wr_have_addr = 2'd1,
      // data held, waiting for address
      wr_have_data = 2'd2,
      // sram written, response pending
      wr_resp      = 2'd3
   } wr_state_e;

   // axi response codes
   typedef enum logic [1:0] {
      // normal access
      okay   = 2'b00,
      // exclusive access ok
      exokay = 2'b01,
      // slave error
      slverr = 2'b10,
      // decode error
      decerr = 2'b11
   } axi_resp_e;

endpackage

/* hw/sync_sram.sv */
`include "sram_bridge_cfg.svh"

module sync_sram (
   input  logic                              aclk,

   // read port
   input  logic                              ren,
   input  logic [`SRAM_DEPTH_LOG2-1:0]       raddr,
   output logic [`AXI_DATA_W-1:0]            rdata,

   // write port
   input  logic [`SRAM_DEPTH_LOG2-1:0]       waddr,
   input  logic [`AXI_DATA_W-1:0]            wdata,
   input  logic [`AXI_STRB_W-1:0]            wen
);

   // word array
   logic [`AXI_DATA_W-1:0] mem [`SRAM_DEPTH];

   // per-byte write, each lane on its own enable
   always_ff @(posedge aclk) begin
      for (int lane = 0; lane < `AXI_STRB_W; lane++) begin
         if (wen[lane]) begin
            mem[waddr][lane*8 +: 8] <= wdata[lane*8 +: 8];
         end
      end
   end

   // read register
   // loads on ren, otherwise keeps the last word read
   // one cycle latency from ren to rdata
   always_ff @(posedge aclk) begin
      if (ren) begin
         rdata <= mem[raddr];
      end
   end

endmodule

/* hw/axi_sram_bridge.sv */
`include "sram_bridge_cfg.svh"

module axi_sram_bridge (
   input  logic                              aclk,
   input  logic                              arst_n,

   // read address channel
   input  logic [`AXI_ADDR_W-1:0]            araddr,
   input  logic                              arvalid,
   output logic                              arready,

   // read data channel
   output logic [`AXI_DATA_W-1:0]            rdata,
   output sram_bridge_pkg::axi_resp_e        rresp,
   output logic                              rlast,
   output logic                              rvalid,
   input  logic                              rready,

   // write address channel
   input  logic [`AXI_ADDR_W-1:0]            awaddr,
   input  logic                              awvalid,
   output logic                              awready,

   // write data channel
   input  logic [`AXI_DATA_W-1:0]            wdata,
   input  logic [`AXI_STRB_W-1:0]            wstrb,
   input  logic                              wvalid,
   output logic                              wready,

   // write response channel
   output sram_bridge_pkg::axi_resp_e        bresp,
   output logic                              bvalid,
   input  logic                              bready,

   // sram side
   output logic                              ram_ren,
   output logic [`SRAM_DEPTH_LOG2-1:0]       ram_raddr,
   input  logic [`AXI_DATA_W-1:0]            ram_rdata,
   output logic [`SRAM_DEPTH_LOG2-1:0]       ram_waddr,
   output logic [`AXI_DATA_W-1:0]            ram_wdata,
   output logic [`AXI_STRB_W-1:0]            ram_wen
);

   import sram_bridge_pkg::*;

   // channel handshakes
   logic                          ar_enter;
   logic                          r_retire;
   logic                          aw_enter;
   logic                          w_enter;
   logic                          b_retire;

   // read outstanding, address accepted and data not yet taken
   logic                          rd_pend;

   // no read outstanding and no write in progress
   logic                          bridge_idle;
   logic                          write_blocked;
   logic                          aw_open;
   logic                          w_open;

   wr_state_e                     wr_state;
   wr_state_e                     wr_state_nxt;

   // one-cycle write strobe on entry to wr_resp
   logic                          wr_fire;

   // captured write payload
   logic [`SRAM_DEPTH_LOG2-1:0]   waddr_q;
   logic [`AXI_DATA_W-1:0]        wdata_q;
   logic [`AXI_STRB_W-1:0]        wstrb_q;

   assign ar_enter = arvalid & arready;
   assign r_retire = rvalid & rready;
   assign aw_enter = awvalid & awready;
   assign w_enter  = wvalid & wready;
   assign b_retire = bvalid & bready;

   // read side

   // sram samples on the accepting edge
   assign ram_ren   = ar_enter;
   assign ram_raddr = araddr[`SRAM_DEPTH_LOG2+`SRAM_WORD_LSB-1:`SRAM_WORD_LSB];

   // set on the address handshake, cleared when the data retires
   // the sram read register is valid exactly one cycle after ren,
   // so the registered flag lines up with the read data
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pend <= 1'b0;
      end else if (ar_enter) begin
         rd_pend <= 1'b1;
      end else if (r_retire) begin
         rd_pend <= 1'b0;
      end
   end

   assign rvalid = rd_pend;
   // sram read register holds while the read is outstanding
   assign rdata  = ram_rdata;
   // single beat only
   assign rlast  = 1'b1;
   assign rresp  = okay;

   // arbitration

   assign bridge_idle = ~rd_pend & (wr_state == wr_idle);

   // read only starts from full idle
   assign arready = bridge_idle;

   // read wins a tie while idle
   assign write_blocked = rd_pend | (arvalid & bridge_idle);

   // each write channel accepts once per transaction
   assign aw_open = (wr_state == wr_idle) | (wr_state == wr_have_data);
   assign w_open  = (wr_state == wr_idle) | (wr_state == wr_have_addr);

   assign awready = aw_open & ~write_blocked;
   assign wready  = w_open & ~write_blocked;

   // write side

   always_comb begin
      wr_state_nxt = wr_state;
      case (wr_state)
         wr_idle: begin
            if (aw_enter && w_enter) begin
               wr_state_nxt = wr_resp;
            end else if (aw_enter) begin
               wr_state_nxt = wr_have_addr;
            end else if (w_enter) begin
               wr_state_nxt = wr_have_data;
            end
         end
         wr_have_addr: begin
            // address held, data completes it
            if (w_enter) begin
               wr_state_nxt = wr_resp;
            end
         end
         wr_have_data: begin
            // data held, address completes it
            if (aw_enter) begin
               wr_state_nxt = wr_resp;
            end
         end
         wr_resp: begin
            if (b_retire) begin
               wr_state_nxt = wr_idle;
            end
         end
         default: begin
            wr_state_nxt = wr_idle;
         end
      endcase
   end

   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         wr_state <= wr_idle;
         wr_fire  <= 1'b0;
      end else begin
         wr_state <= wr_state_nxt;
         // high only for the first cycle spent in wr_resp
         wr_fire  <= (wr_state != wr_resp) && (wr_state_nxt == wr_resp);
      end
   end

   // payload capture, each on its own handshake
   always_ff @(posedge aclk) begin
      if (aw_enter) begin
         waddr_q <= awaddr[`SRAM_DEPTH_LOG2+`SRAM_WORD_LSB-1:`SRAM_WORD_LSB];
      end
      if (w_enter) begin
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   assign ram_waddr = waddr_q;
   assign ram_wdata = wdata_q;
   // byte-masked write, one cycle per transaction
   assign ram_wen   = {`AXI_STRB_W{wr_fire}} & wstrb_q;

   // response held until bready
   assign bvalid = (wr_state == wr_resp);
   assign bresp  = okay;

endmodule

/* hw/axi_sram_top.sv */
`include "sram_bridge_cfg.svh"

module axi_sram_top (
   input  logic                              aclk,
   input  logic                              arst_n,

   // read address channel
   input  logic [`AXI_ADDR_W-1:0]            araddr,
   input  logic                              arvalid,
   output logic                              arready,

   // read data channel
   output logic [`AXI_DATA_W-1:0]            rdata,
   output sram_bridge_pkg::axi_resp_e        rresp,
   output logic                              rlast,
   output logic                              rvalid,
   input  logic                              rready,

   // write address channel
   input  logic [`AXI_ADDR_W-1:0]            awaddr,
   input  logic                              awvalid,
   output logic                              awready,

   // write data channel
   input  logic [`AXI_DATA_W-1:0]            wdata,
   input  logic [`AXI_STRB_W-1:0]            wstrb,
   input  logic                              wvalid,
   output logic                              wready,

   // write response channel
   output sram_bridge_pkg::axi_resp_e        bresp,
   output logic                              bvalid,
   input  logic                              bready
);

   // bridge to sram strobes
   logic                          ram_ren;
   logic [`SRAM_DEPTH_LOG2-1:0]   ram_raddr;
   logic [`AXI_DATA_W-1:0]        ram_rdata;
   logic [`SRAM_DEPTH_LOG2-1:0]   ram_waddr;
   logic [`AXI_DATA_W-1:0]        ram_wdata;
   logic [`AXI_STRB_W-1:0]        ram_wen;

   axi_sram_bridge u_bridge (
      .aclk      (aclk),
      .arst_n    (arst_n),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rlast     (rlast),
      .rvalid    (rvalid),
      .rready    (rready),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .ram_ren   (ram_ren),
      .ram_raddr (ram_raddr),
      .ram_rdata (ram_rdata),
      .ram_waddr (ram_waddr),
      .ram_wdata (ram_wdata),
      .ram_wen   (ram_wen)
   );

   // single-port style sram, one cycle read latency
   sync_sram u_sram (
      .aclk  (aclk),
      .ren   (ram_ren),
      .raddr (ram_raddr),
      .rdata (ram_rdata),
      .waddr (ram_waddr),
      .wdata (ram_wdata),
      .wen   (ram_wen)
   );

endmodule

/* testbench/tb_axi_sram_top.sv */
`include "sram_bridge_cfg.svh"

module tb_axi_sram_top;

   timeunit 1ns;
   timeprecision 100ps;

   import sram_bridge_pkg::*;

   // clock period in ns
   localparam int CLK_PERIOD = 40;
   // watchdog budget per pattern line and for the whole run
   localparam int CYCLES_PER_LINE = 40;
   localparam int CYCLES_SPARE = 100;

   logic                   aclk = 1'b0;
   logic                   arst_n;
   logic [`AXI_ADDR_W-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   logic [`AXI_DATA_W-1:0] rdata;
   axi_resp_e              rresp;
   logic                   rlast;
   logic                   rvalid;
   logic                   rready;
   logic [`AXI_ADDR_W-1:0] awaddr;
   logic                   awvalid;
   logic                   awready;
   logic [`AXI_DATA_W-1:0] wdata;
   logic [`AXI_STRB_W-1:0] wstrb;
   logic                   wvalid;
   logic                   wready;
   axi_resp_e              bresp;
   logic                   bvalid;
   logic                   bready;

   // parsed pattern lines
   // pat_src holds the line number in the file
   logic [7:0]             pat_op[$];
   logic [`AXI_ADDR_W-1:0] pat_addr[$];
   logic [`AXI_DATA_W-1:0] pat_data[$];
   logic [`AXI_STRB_W-1:0] pat_strb[$];
   logic [`AXI_DATA_W-1:0] pat_exp[$];
   int                     pat_src[$];

   int                     err_count;
   int                     cur_line;
   logic                   loaded;
   logic [31:0]            rng;

   axi_sram_top u_dut (.*);

   always #(CLK_PERIOD / 2) aclk = ~aclk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic report_error(input string msg);
      $display("** Error at %0d ns, pattern line %0d: %s", $time, cur_line, msg);
      err_count++;
   endtask

   task automatic load_patterns(output logic ok);
      int                     fd;
      int                     cnt;
      int                     src;
      string                  line;
      logic [7:0]             op;
      logic [`AXI_ADDR_W-1:0] a;
      logic [`AXI_DATA_W-1:0] d;
      logic [`AXI_STRB_W-1:0] s;
      logic [`AXI_DATA_W-1:0] e;
      ok = 1'b1;
      src = 0;
      fd = $fopen("testbench/axi_sram_patterns.txt", "r");
      if (fd == 0) begin
         $display("cannot open testbench/axi_sram_patterns.txt");
         ok = 1'b0;
      end else begin
         while ($fgets(line, fd) != 0) begin
            src++;
            // blank lines and comments
            if (line.len() < 2 || line.getc(0) == "#") begin
               continue;
            end
            cnt = $sscanf(line, "%c %h %h %h %h", op, a, d, s, e);
            if (cnt != 5) begin
               $display("pattern line %0d is malformed", src);
               ok = 1'b0;
            end else begin
               pat_op.push_back(op);
               pat_addr.push_back(a);
               pat_data.push_back(d);
               pat_strb.push_back(s);
               pat_exp.push_back(e);
               pat_src.push_back(src);
            end
         end
         $fclose(fd);
         if (pat_op.size() == 0) begin
            $display("pattern file holds no transactions");
            ok = 1'b0;
         end
      end
   endtask

   // bridge idle with every ready up and nothing valid
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge aclk);
         arvalid = 1'b0;
         awvalid = 1'b0;
         wvalid  = 1'b0;
         rready  = 1'b0;
         bready  = 1'b0;
         #1;
         assert (arready && awready && wready)
            else report_error("ready low while the bridge is idle");
         assert (!rvalid && !bvalid)
            else report_error("valid high with nothing outstanding");
         assert (u_dut.ram_wen == '0)
            else report_error("sram write strobe while idle");
      end
   endtask

   // one read, one write, or both raised together
   // every check samples 1 ns after the falling edge, where all
   // outputs are settled until the next rising edge
   task automatic run_access(input logic do_rd, input logic do_wr,
                             input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_DATA_W-1:0] data,
                             input logic [`AXI_STRB_W-1:0] strb,
                             input logic [`AXI_DATA_W-1:0] exp_word);
      int                     cyc;
      int                     order;
      int                     r_delay;
      int                     b_delay;
      int                     r_seen;
      int                     b_seen;
      int                     ar_cyc;
      int                     wr_cyc;
      logic                   ar_done;
      logic                   r_done;
      logic                   aw_done;
      logic                   w_done;
      logic                   b_done;
      logic                   ar_hs;
      logic                   aw_hs;
      logic                   w_hs;
      logic [`AXI_DATA_W-1:0] held;
      rng = xorshift32(rng);
      order = int'(rng % 32'd3);
      rng = xorshift32(rng);
      r_delay = int'(rng[1:0]);
      b_delay = int'(rng[3:2]);
      cyc = 0;
      r_seen = 0;
      b_seen = 0;
      ar_cyc = -1;
      wr_cyc = -1;
      ar_done = 1'b0;
      r_done = 1'b0;
      aw_done = 1'b0;
      w_done = 1'b0;
      b_done = 1'b0;
      held = '0;
      while ((do_rd && !r_done) || (do_wr && !b_done)) begin
         @(negedge aclk);
         araddr  = addr;
         awaddr  = addr;
         wdata   = data;
         wstrb   = strb;
         arvalid = do_rd && !ar_done;
         // order 0 puts aw first, 1 puts w first, 2 raises both
         awvalid = do_wr && !aw_done && (order != 1 || w_done);
         wvalid  = do_wr && !w_done && (order != 0 || aw_done);
         // ready held low for the drawn number of valid cycles
         rready  = (r_seen >= r_delay);
         bready  = (b_seen >= b_delay);
         #1;
         // read wins a tie in the idle state
         if (arvalid && arready) begin
            assert (!awready && !wready)
               else report_error("write ready high while a read is accepted");
         end
         if (ar_done && !r_done) begin
            assert (!arready && !awready && !wready)
               else report_error("ready high while read data is outstanding");
            if (cyc == ar_cyc + 1) begin
               assert (rvalid)
                  else report_error("rvalid not one cycle after the read address");
            end
            if (rvalid && r_seen == 0) begin
               held = rdata;
               assert (rdata == exp_word)
                  else report_error($sformatf("rdata %h, expected %h", rdata, exp_word));
               assert (rresp == okay && rlast)
                  else report_error("rresp not okay or rlast low");
            end else if (r_seen > 0) begin
               assert (rvalid && rdata == held)
                  else report_error("read data not held under back-pressure");
            end
         end else begin
            assert (!rvalid)
               else report_error("rvalid with no read outstanding");
         end
         // each write channel accepts once per transaction
         if (aw_done && !b_done) begin
            assert (!awready)
               else report_error("awready high before the response retired");
         end
         if (w_done && !b_done) begin
            assert (!wready)
               else report_error("wready high before the response retired");
         end
         if (aw_done && w_done && !b_done) begin
            if (cyc == wr_cyc + 1) begin
               assert (bvalid)
                  else report_error("bvalid not one cycle after the later capture");
            end
            if (bvalid) begin
               assert (bresp == okay)
                  else report_error("bresp not okay");
            end
            if (b_seen > 0) begin
               assert (bvalid)
                  else report_error("bvalid dropped before bready");
            end
         end else begin
            assert (!bvalid)
               else report_error("bvalid with no write captured");
         end
         // one masked strobe in the first response cycle only
         if (do_wr && aw_done && w_done && cyc == wr_cyc + 1) begin
            assert (u_dut.ram_wen == strb)
               else report_error($sformatf("ram_wen %h, expected %h", u_dut.ram_wen, strb));
         end else begin
            assert (u_dut.ram_wen == '0)
               else report_error("sram write strobe outside the first response cycle");
         end
         // handshakes happen on the coming rising edge
         ar_hs = arvalid && arready;
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         if ((aw_hs || w_hs) && (aw_done || aw_hs) && (w_done || w_hs)) begin
            wr_cyc = cyc;
         end
         if (ar_done && !r_done && rvalid) begin
            r_done = rready;
            r_seen++;
         end
         if (aw_done && w_done && !b_done && bvalid) begin
            b_done = bready;
            b_seen++;
         end
         if (ar_hs) begin
            ar_done = 1'b1;
            ar_cyc = cyc;
         end
         aw_done = aw_done | aw_hs;
         w_done  = w_done | w_hs;
         cyc++;
      end
   endtask

   initial begin : main_seq
      logic load_ok;
      arst_n    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      err_count = 0;
      cur_line  = 0;
      loaded    = 1'b0;
      rng       = 32'h5cd3c3b6;
      load_patterns(load_ok);
      if (load_ok) begin
         loaded = 1'b1;
         // reset over three rising edges, released on a falling one
         repeat (3) @(posedge aclk);
         @(negedge aclk);
         arst_n = 1'b1;
         idle_cycles(1);
         for (int i = 0; i < pat_op.size(); i++) begin
            cur_line = pat_src[i];
            case (pat_op[i])
               "W": run_access(1'b0, 1'b1, pat_addr[i], pat_data[i], pat_strb[i], pat_exp[i]);
               "R": run_access(1'b1, 1'b0, pat_addr[i], pat_data[i], pat_strb[i], pat_exp[i]);
               "A": run_access(1'b1, 1'b1, pat_addr[i], pat_data[i], pat_strb[i], pat_exp[i]);
               // address column is the gap length
               "Q": idle_cycles(int'(pat_addr[i]));
               default: begin
                  $display("pattern line %0d has unknown opcode %c", cur_line, pat_op[i]);
                  err_count++;
               end
            endcase
            // every retired transaction leaves the bridge idle
            idle_cycles(1);
         end
      end else begin
         $display("pattern file could not be loaded, no transactions run");
         err_count++;
      end
      $display("tb_axi_sram_top done: %0d pattern lines, %0d errors", pat_op.size(), err_count);
      if (err_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin : watchdog
      wr_state_e st;
      wait (loaded);
      #((pat_op.size() * CYCLES_PER_LINE + CYCLES_SPARE) * CLK_PERIOD);
      st = u_dut.u_bridge.wr_state;
      $display("run timed out with pattern line %0d still pending, write state %s, %0d errors",
               cur_line, st.name(), err_count);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* testbench/axi_sram_patterns.txt */
# columns: op addr data strb expect, all hex except op
# W write data under strb, R read and expect, A read and write raised together, Q idle addr cycles
W 00000000 11223344 f 00000000
R 00000000 00000000 0 11223344
W 00000004 a5a5a5a5 f 00000000
W 00000008 deadbeef f 00000000
R 00000004 00000000 0 a5a5a5a5
R 00000008 00000000 0 deadbeef
# partial strobes merge into the stored word
W 00000004 000000cc 1 00000000
R 00000004 00000000 0 a5a5a5cc
W 00000004 00bb0000 4 00000000
R 00000004 00000000 0 a5bba5cc
W 00000008 12345678 c 00000000
R 00000008 00000000 0 1234beef
W 00000008 9abcdef0 3 00000000
R 00000008 00000000 0 1234def0
# zero strobe completes but changes nothing
W 00000008 ffffffff 0 00000000
R 00000008 00000000 0 1234def0
Q 00000005 00000000 0 00000000
# top word of the array
W 000003fc 0f0f0f0f f 00000000
R 000003fc 00000000 0 0f0f0f0f
W 00000100 cafef00d f 00000000
W 00000104 01020304 f 00000000
W 00000108 55aa55aa f 00000000
R 00000100 00000000 0 cafef00d
R 00000104 00000000 0 01020304
R 00000108 00000000 0 55aa55aa
W 00000104 ee000000 8 00000000
W 00000104 0000dd00 2 00000000
R 00000104 00000000 0 ee02dd04
# read wins and returns the old word, the write follows
A 00000100 600dc0de f cafef00d
R 00000100 00000000 0 600dc0de
A 00000108 00000077 1 55aa55aa
R 00000108 00000000 0 55aa5577
A 000003fc 80000000 8 0f0f0f0f
R 000003fc 00000000 0 800f0f0f
Q 00000003 00000000 0 00000000
W 00000010 13579bdf f 00000000
R 00000010 00000000 0 13579bdf
R 00000010 00000000 0 13579bdf
R 00000000 00000000 0 11223344
W 00000000 aabbccdd 6 00000000
R 00000000 00000000 0 11bbcc44
A 00000000 01010101 9 11bbcc44
R 00000000 00000000 0 01bbcc01

/* all.f */
+incdir+hw
hw/sram_bridge_pkg.sv
hw/sync_sram.sv
hw/axi_sram_bridge.sv
hw/axi_sram_top.sv
testbench/tb_axi_sram_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the axi to sram bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_axi_sram

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f all.f --top-module tb_axi_sram_top -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# pass only when the testbench printed its pass line
if grep -q "^Simulation completed successfully$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL, see $LOG"
   exit 1
fi
